// ==== files.f ====
axi_pkg.sv
wb_pkg.sv
wb_aw_channel.sv
wb_w_channel.sv
wb_write_ctrl.sv
wb_axi_writer.sv
wb_axi_writer_asserts.sv
tb_wb_axi_writer.sv

// ==== Makefile ====
# Verilator build and run for the write-back AXI4 writer testbench.

VERILATOR ?= verilator
TOP       ?= tb_wb_axi_writer
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL TESTS PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_wb_axi_writer.sv ====
// Testbench for the write-back AXI4 writer with a reactive AXI slave model and checks.
`timescale 1ns/1ps

module tb_wb_axi_writer
    import axi_pkg::*;
    import wb_pkg::*;
();

    const int timeout_cycles = 2000;

    logic      clk = 1'b0;
    logic      rstn;
    logic      req_valid;
    wb_req_t   req;
    logic      req_ready;
    logic      done;
    axi_resp_e resp;
    logic      done_ack;
    logic      awvalid;
    axi_aw_t   aw;
    logic      awready = 1'b0;
    logic      wvalid;
    axi_w_t    w;
    logic      wready = 1'b0;
    logic      bvalid = 1'b0;
    axi_resp_e bresp = OKAY;
    logic      bready;

    logic      stall_en;
    axi_resp_e next_bresp;
    axi_resp_e last_bresp = OKAY;
    bit        aw_accepted = 1'b0;
    bit        wlast_accepted = 1'b0;
    int        slave_errs = 0;
    axi_aw_t   aw_log[$];
    axi_w_t    w_log[$];
    wb_req_t   sent_q[$];
    event      xfer_ended;
    int        err_cnt;
    int        tests_run;
    int        tests_failed;

    wb_axi_writer wb_axi_writer_i (.*);

    always #20 clk = ~clk;

    // ==================================================
    // reference model
    // ==================================================
    // fills the expected AW fields and W beats and returns the beat count.
    function automatic int predict_write(input wb_req_t r, output axi_aw_t aw_exp,
                                         output axi_w_t beats [line_words]);
        int n;
        int first;
        aw_exp.size  = 3'd2;
        aw_exp.burst = INCR;
        if (r.uncache) begin
            aw_exp.addr = {r.addr[31:2], 2'b00};
            aw_exp.len  = 8'd0;
            n           = 1;
            first       = int'(r.addr[5:2]);   // word picked by the address.
        end else begin
            aw_exp.addr = {r.addr[31:6], 6'b000000};
            aw_exp.len  = 8'd15;
            n           = 16;
            first       = 0;
        end
        for (int i = 0; i < n; i++) begin
            beats[i].data = r.line[(first + i) * 32 +: 32];
            beats[i].strb = 4'hf;
            beats[i].last = (i == n - 1);
        end
        return n;
    endfunction

    function automatic wb_req_t make_req(input bit unc);
        wb_req_t r;
        r.addr    = $urandom;
        r.uncache = unc;
        for (int i = 0; i < line_words; i++) begin
            r.line[i*32 +: 32] = $urandom;
        end
        return r;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("t=%0t %s", $time, why);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    // ==================================================
    // AXI slave model
    // ==================================================
    always @(posedge clk) begin
        if (rstn) begin
            if (bready) begin
                assert (aw_accepted && wlast_accepted) else begin
                    $display("t=%0t bready rose before AW and the last W beat were accepted",
                             $time);
                    slave_errs++;
                end
            end
            if (awvalid && awready) begin
                aw_log.push_back(aw);
                aw_accepted = 1'b1;
            end
            if (wvalid && wready) begin
                w_log.push_back(w);
                if (w.last) begin
                    wlast_accepted = 1'b1;
                end
            end
            if (bvalid && bready) begin
                last_bresp     = bresp;
                aw_accepted    = 1'b0;
                wlast_accepted = 1'b0;
                bvalid <= 1'b0;
            end else if (!bvalid && aw_accepted && wlast_accepted &&
                         (!stall_en || $urandom_range(2) == 0)) begin
                bvalid <= 1'b1;   // response only after both channels.
                bresp  <= next_bresp;
            end
            awready <= !stall_en || ($urandom_range(3) != 0);
            wready  <= !stall_en || ($urandom_range(3) != 0);
        end
    end

    // ==================================================
    // compare process
    // ==================================================
    initial begin : compare_logs
        wb_req_t r;
        axi_aw_t aw_exp;
        axi_aw_t aw_got;
        axi_w_t  beats [line_words];
        axi_w_t  w_got;
        int      n;
        forever begin
            @(xfer_ended);
            r = sent_q.pop_front();
            n = predict_write(r, aw_exp, beats);
            assert (aw_log.size() == 1) else begin
                $display("t=%0t expected one AW handshake, saw %0d", $time, aw_log.size());
                err_cnt++;
            end
            if (aw_log.size() > 0) begin
                aw_got = aw_log.pop_front();
                compare_field("aw.addr", aw_got.addr, aw_exp.addr);
                compare_field("aw.len", 32'(aw_got.len), 32'(aw_exp.len));
                compare_field("aw.size", 32'(aw_got.size), 32'(aw_exp.size));
                compare_field("aw.burst", 32'(aw_got.burst), 32'(aw_exp.burst));
            end
            assert (w_log.size() == n) else begin
                $display("t=%0t expected %0d W beats, saw %0d", $time, n, w_log.size());
                err_cnt++;
            end
            for (int i = 0; i < n && w_log.size() > 0; i++) begin
                w_got = w_log.pop_front();
                compare_field("w.data", w_got.data, beats[i].data);
                compare_field("w.strb", 32'(w_got.strb), 32'(beats[i].strb));
                compare_field("w.last", 32'(w_got.last), 32'(beats[i].last));
            end
            aw_log.delete();
            w_log.delete();
        end
    end

    // ==================================================
    // request side
    // ==================================================
    task automatic send_request(input wb_req_t r);
        int n;
        n = 0;
        req       <= r;
        req_valid <= 1'b1;
        @(posedge clk);
        while (!req_ready && n < timeout_cycles) begin
            @(posedge clk);
            n++;
        end
        if (!req_ready) begin
            abort_run("timeout waiting for req_ready");
        end else begin
            req_valid <= 1'b0;
            sent_q.push_back(r);
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < timeout_cycles) begin
            @(posedge clk);
            n++;
        end
        if (!done) begin
            abort_run("timeout waiting for done");
        end else begin
            -> xfer_ended;
            compare_field("resp", 32'(resp), 32'(last_bresp));
        end
    endtask

    task automatic ack_done();
        done_ack <= 1'b1;
        @(posedge clk);
        done_ack <= 1'b0;
        @(posedge clk);
        compare_field("req_ready", 32'(req_ready), 32'd1);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt + slave_errs == errs_before) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", tests_run, name,
                     err_cnt + slave_errs - errs_before);
        end
    endtask

    // ==================================================
    // test sequence
    // ==================================================
    initial begin : main_seq
        int base;
        void'($urandom(32'h5fcb));
        rstn = 1'b0;
        req_valid = 1'b0;
        req = '0;
        done_ack = 1'b0;
        stall_en = 1'b0;
        next_bresp = OKAY;
        err_cnt = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        base = err_cnt + slave_errs;
        compare_field("req_ready", 32'(req_ready), 32'd1);
        compare_field("awvalid", 32'(awvalid), 32'd0);
        compare_field("wvalid", 32'(wvalid), 32'd0);
        compare_field("bready", 32'(bready), 32'd0);
        compare_field("done", 32'(done), 32'd0);
        report_test("reset state", base);

        base = err_cnt + slave_errs;
        send_request(make_req(1'b0));
        wait_done();
        ack_done();
        report_test("cached burst", base);

        base = err_cnt + slave_errs;
        send_request(make_req(1'b1));
        wait_done();
        ack_done();
        report_test("uncached word", base);

        base = err_cnt + slave_errs;
        stall_en = 1'b1;
        for (int i = 0; i < 6; i++) begin
            send_request(make_req(i[0]));
            wait_done();
            ack_done();
        end
        report_test("ready stalls", base);

        // response held until ack, and no request taken while done is high.
        base = err_cnt + slave_errs;
        next_bresp = SLVERR;
        send_request(make_req(1'b0));
        wait_done();
        req       <= make_req(1'b1);
        req_valid <= 1'b1;
        repeat (4) begin
            @(posedge clk);
            compare_field("done", 32'(done), 32'd1);
            compare_field("resp", 32'(resp), 32'(SLVERR));
            compare_field("awvalid", 32'(awvalid), 32'd0);
        end
        req_valid <= 1'b0;
        ack_done();
        repeat (3) @(posedge clk);
        assert (aw_log.size() == 0 && !awvalid) else begin
            $display("t=%0t a request offered while req_ready was low was accepted", $time);
            err_cnt++;
        end
        report_test("response and ack", base);

        base = err_cnt + slave_errs;
        for (int i = 0; i < 20; i++) begin
            next_bresp = axi_resp_e'($urandom_range(3));
            send_request(make_req($urandom_range(1) == 1));
            wait_done();
            ack_done();
        end
        report_test("random mix", base);

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, err_cnt + slave_errs);
        if (tests_failed == 0 && err_cnt + slave_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== wb_axi_writer_asserts.sv ====
// Handshake and request-ordering assertions for the write-back AXI4 writer.
`timescale 1ns/1ps

module wb_axi_writer_asserts
    import axi_pkg::*;
    import wb_pkg::*;
(
    input logic      clk,
    input logic      rstn,
    input logic      req_valid,
    input logic      req_ready,
    input logic      done,
    input logic      awvalid,
    input logic      awready,
    input axi_aw_t   aw,
    input logic      wvalid,
    input logic      wready,
    input axi_w_t    w,
    input logic      bready,
    input wb_state_e state
);

    // ==================================================
    // AXI handshake stability
    // ==================================================
    aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("awvalid or aw changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (!rstn)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("wvalid or w changed before wready");

    // ==================================================
    // controller and request ordering
    // ==================================================
    bready_state: assert property (@(posedge clk) disable iff (!rstn)
        bready |-> state == WAIT_B)
        else $error("bready high outside WAIT_B");

    done_not_ready: assert property (@(posedge clk) disable iff (!rstn)
        !(done && req_ready))
        else $error("done and req_ready high together");

    // an accepted request puts both channels up at the next edge.
    accept_starts: assert property (@(posedge clk) disable iff (!rstn)
        req_valid && req_ready |=> awvalid && wvalid && state == ISSUE)
        else $error("accepted request did not start both channels");

endmodule

bind wb_axi_writer wb_axi_writer_asserts wb_axi_writer_asserts_i (
    .clk       (clk),
    .rstn      (rstn),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .done      (done),
    .awvalid   (awvalid),
    .awready   (awready),
    .aw        (aw),
    .wvalid    (wvalid),
    .wready    (wready),
    .w         (w),
    .bready    (bready),
    .state     (wb_write_ctrl_i.state)
);

// ==== wb_axi_writer.sv ====
// Write-back AXI4 writer top: request port, controller and both write channels.
`timescale 1ns/1ps

module wb_axi_writer
    import axi_pkg::*;
    import wb_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    // request side.
    input  logic      req_valid,
    input  wb_req_t   req,
    output logic      req_ready,
    output logic      done,
    output axi_resp_e resp,
    input  logic      done_ack,
    // AXI write address.
    output logic      awvalid,
    output axi_aw_t   aw,
    input  logic      awready,
    // AXI write data.
    output logic      wvalid,
    output axi_w_t    w,
    input  logic      wready,
    // AXI write response.
    input  logic      bvalid,
    input  axi_resp_e bresp,
    output logic      bready
);

    logic start;
    logic aw_done;
    logic w_done;

    // ==================================================
    // control
    // ==================================================
    wb_write_ctrl wb_write_ctrl_i (
        .clk       (clk),
        .rstn      (rstn),
        .req_valid (req_valid),
        .aw_done   (aw_done),
        .w_done    (w_done),
        .bvalid    (bvalid),
        .bresp     (bresp),
        .done_ack  (done_ack),
        .req_ready (req_ready),
        .start     (start),
        .bready    (bready),
        .done      (done),
        .resp      (resp)
    );

    // ==================================================
    // channels
    // ==================================================
    wb_aw_channel wb_aw_channel_i (
        .clk     (clk),
        .rstn    (rstn),
        .start   (start),
        .req     (req),
        .awready (awready),
        .awvalid (awvalid),
        .aw      (aw),
        .aw_done (aw_done)
    );

    wb_w_channel wb_w_channel_i (
        .clk    (clk),
        .rstn   (rstn),
        .start  (start),
        .req    (req),
        .wready (wready),
        .wvalid (wvalid),
        .w      (w),
        .w_done (w_done)
    );

endmodule

// ==== wb_write_ctrl.sv ====
// Write controller: accepts a request, starts both channels and joins their completion.
`timescale 1ns/1ps

module wb_write_ctrl
    import axi_pkg::*;
    import wb_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      req_valid,
    input  logic      aw_done,
    input  logic      w_done,
    input  logic      bvalid,
    input  axi_resp_e bresp,
    input  logic      done_ack,
    output logic      req_ready,
    output logic      start,
    output logic      bready,
    output logic      done,
    output axi_resp_e resp
);

    wb_state_e state;
    wb_state_e state_nxt;
    logic      aw_seen;
    logic      w_seen;
    logic      aw_all;
    logic      w_all;

    // a pulse in this cycle counts as well as an earlier one.
    assign aw_all = aw_seen | aw_done;
    assign w_all  = w_seen | w_done;

    // ==================================================
    // state machine
    // ==================================================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (req_valid) state_nxt = ISSUE;
            ISSUE:   if (aw_all && w_all) state_nxt = WAIT_B;
            WAIT_B:  if (bvalid) state_nxt = FINISH;
            FINISH:  if (done_ack) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // sticky completion flags, cleared per request.
    always_ff @(posedge clk) begin
        if (!rstn || start) begin
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
        end else if (state == ISSUE) begin
            if (aw_done) aw_seen <= 1'b1;
            if (w_done) w_seen <= 1'b1;
        end
    end

    // response captured on the B handshake.
    always_ff @(posedge clk) begin
        if (bvalid && bready) begin
            resp <= bresp;
        end
    end

    // ==================================================
    // outputs
    // ==================================================
    assign req_ready = (state == IDLE);
    assign start     = req_valid & req_ready;
    assign bready    = (state == WAIT_B);
    assign done      = (state == FINISH);

endmodule

// ==== wb_w_channel.sv ====
// Write data streamer: holds the line and sends its words as W beats.
`timescale 1ns/1ps

module wb_w_channel
    import axi_pkg::*;
    import wb_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  logic    start,
    input  wb_req_t req,
    input  logic    wready,
    output logic    wvalid,
    output axi_w_t  w,
    output logic    w_done
);

    logic [line_bytes*8-1:0] line_q;
    logic                    uncache_q;
    logic [beat_cnt_w-1:0]   beat_q;
    logic                    w_fire;

    assign w_fire = wvalid & wready;

    // ==================================================
    // line storage
    // ==================================================
    always_ff @(posedge clk) begin
        if (start) begin
            line_q    <= req.line;
            uncache_q <= req.uncache;
        end
    end

    // ==================================================
    // beat counter and valid
    // ==================================================
    // an uncached write starts on the addressed word and sends only that.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wvalid <= 1'b0;
            beat_q <= '0;
        end else if (start) begin
            wvalid <= 1'b1;
            if (req.uncache) begin
                beat_q <= req.addr[beat_cnt_w+1:2];
            end else begin
                beat_q <= '0;
            end
        end else if (w_fire) begin
            if (w.last) begin
                wvalid <= 1'b0;   // burst complete.
            end else begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // ==================================================
    // beat payload
    // ==================================================
    always_comb begin
        w.data = line_q[beat_q * axi_data_w +: axi_data_w];
        w.strb = '1;   // full words only.
        w.last = uncache_q || (beat_q == beat_cnt_w'(line_words - 1));
    end

    assign w_done = w_fire & w.last;

endmodule

// ==== wb_aw_channel.sv ====
// Write address issuer: forms the burst shape and holds awvalid until accepted.
`timescale 1ns/1ps

module wb_aw_channel
    import axi_pkg::*;
    import wb_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  logic    start,
    input  wb_req_t req,
    input  logic    awready,
    output logic    awvalid,
    output axi_aw_t aw,
    output logic    aw_done
);

    // ==================================================
    // address and burst shape
    // ==================================================
    // cached lines go out as a full INCR burst from the line base.
    always_ff @(posedge clk) begin
        if (start) begin
            aw.size  <= 3'($clog2(axi_data_w / 8));
            aw.burst <= INCR;
            if (req.uncache) begin
                aw.addr <= req.addr & ~axi_addr_w'(axi_data_w / 8 - 1);   // word aligned.
                aw.len  <= 8'd0;
            end else begin
                aw.addr <= req.addr & ~axi_addr_w'(line_bytes - 1);   // line aligned.
                aw.len  <= 8'(line_words - 1);
            end
        end
    end

    // ==================================================
    // valid handshake
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            awvalid <= 1'b0;
        end else if (start) begin
            awvalid <= 1'b1;
        end else if (awready) begin
            awvalid <= 1'b0;   // accepted.
        end
    end

    assign aw_done = awvalid & awready;   // single cycle, valid drops after.

endmodule

// ==== wb_pkg.sv ====
// Write-buffer line geometry, controller states and the cache request format.
package wb_pkg;

    // ==================================================
    // line geometry
    // ==================================================
    // a dirty line is 64 bytes, sent as sixteen 32-bit words.
    localparam int line_bytes = 64;
    localparam int line_words = 16;
    localparam int beat_cnt_w = 4;

    // ==================================================
    // controller states
    // ==================================================
    typedef enum logic [1:0] {
        IDLE   = 2'b00,   // waiting for a request.
        ISSUE  = 2'b01,   // aw and w in flight.
        WAIT_B = 2'b10,   // both sent, waiting on response.
        FINISH = 2'b11    // done held until ack.
    } wb_state_e;

    // ==================================================
    // request from the cache
    // ==================================================
    typedef struct packed {
        logic [31:0]             addr;
        logic [line_bytes*8-1:0] line;
        logic                    uncache;   // single word write.
    } wb_req_t;

endpackage

// ==== axi_pkg.sv ====
// AXI4 write-channel definitions shared by the write-back path.
package axi_pkg;

    // ==================================================
    // bus widths
    // ==================================================
    localparam int axi_addr_w = 32;
    localparam int axi_data_w = 32;

    // ==================================================
    // encodings
    // ==================================================
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // ==================================================
    // channel payloads
    // ==================================================
    typedef struct packed {
        logic [axi_addr_w-1:0] addr;
        logic [7:0]            len;    // beats minus one.
        logic [2:0]            size;   // log2 of bytes per beat.
        axi_burst_e            burst;
    } axi_aw_t;

    typedef struct packed {
        logic [axi_data_w-1:0]   data;
        logic [axi_data_w/8-1:0] strb;
        logic                    last;
    } axi_w_t;

endpackage
